/* include/asi_settings.svh */
// ----------------------------------------------------------------------
// AXI4 read slave build settings
// Bus widths, buffer depths and memory latency
// ----------------------------------------------------------------------
`ifndef ASI_SETTINGS_SVH
`define ASI_SETTINGS_SVH

// AXI channel field widths
`define ASI_DW 32
`define ASI_AW 16
`define ASI_IW 4
`define ASI_LW 8
`define ASI_SW 3

// Outstanding burst slots in the AR buffer
`define ASI_AR_DEPTH 4
// Beats held in the R buffer
`define ASI_R_DEPTH 16

// Memory read latency in cycles, must be 1 or more
`define ASI_RAM_WAIT 1

// Bytes carried by one beat of the data bus
`define ASI_BYTES (`ASI_DW / 8)
// Widest legal transfer size code
`define ASI_MAX_SIZE $clog2(`ASI_BYTES)

`endif

/* source/asi_pkg.sv */
// ----------------------------------------------------------------------
// AXI4 read slave shared types
// Field vectors and the enums for burst, phase and response
// ----------------------------------------------------------------------
`include "asi_settings.svh"

package asi_pkg;

    // AXI field vectors
    typedef logic [`ASI_IW-1:0] axi_id_t;
    typedef logic [`ASI_AW-1:0] axi_addr_t;
    typedef logic [`ASI_LW-1:0] axi_len_t;
    typedef logic [`ASI_SW-1:0] axi_size_t;
    typedef logic [`ASI_DW-1:0] axi_data_t;

    // ARBURST encoding
    typedef enum logic [1:0] {
        BT_FIXED    = 2'd0,
        BT_INCR     = 2'd1,
        BT_WRAP     = 2'd2,
        BT_RESERVED = 2'd3
    } burst_type_e;

    // Burst engine phase
    // First beat comes from the FIFO head, the rest from latched fields
    typedef enum logic [1:0] {BP_IDLE, BP_FIRST, BP_BURST} burst_phase_e;

    // RRESP encoding, only the two codes this slave returns
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

endpackage

/* source/asi_read_slave.sv */
// ----------------------------------------------------------------------
// AXI4 read slave front end, top level
// AR buffer, burst engine, return pipe and R buffer
// ----------------------------------------------------------------------
`include "asi_settings.svh"
`timescale 1ns/1ps

module asi_read_slave import asi_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // AR channel
    input  axi_id_t     arid,
    input  axi_addr_t   araddr,
    input  axi_len_t    arlen,
    input  axi_size_t   arsize,
    input  burst_type_e arburst,
    input  logic        arvalid,
    output logic        arready,
    // R channel
    output axi_id_t     rid,
    output axi_data_t   rdata,
    output resp_e       rresp,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    // Memory side
    output axi_addr_t   m_raddr,
    output logic        m_re,
    input  axi_data_t   m_rdata
);

    // FIFO word widths
    localparam int AR_W = `ASI_IW + `ASI_AW + `ASI_LW + `ASI_SW + 2;
    localparam int R_W  = `ASI_IW + `ASI_DW + 3;

    // AR buffer
    logic [AR_W-1:0] ar_dout;
    logic            ar_full;
    logic            ar_empty;
    logic            aq_pop;
    axi_id_t         aq_id;
    axi_addr_t       aq_addr;
    axi_len_t        aq_len;
    axi_size_t       aq_size;
    logic [1:0]      aq_burst_raw;

    // Beat tags and credit
    axi_id_t         beat_id;
    resp_e           beat_resp;
    logic            beat_last;
    logic            stall;

    // R buffer
    logic            rff_push;
    logic [R_W-1:0]  rff_din;
    logic [R_W-1:0]  r_dout;
    logic            r_empty;
    logic [$clog2(`ASI_R_DEPTH+1)-1:0] rff_count;
    logic [1:0]      rresp_raw;

    // ------------------------------------------------------------------
    // AR side
    // ------------------------------------------------------------------
    assign arready = !ar_full;
    assign {aq_id, aq_addr, aq_len, aq_size, aq_burst_raw} = ar_dout;

    sync_fifo #(
        .DEPTH (`ASI_AR_DEPTH),
        .WIDTH (AR_W)
    ) ar_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (arvalid && arready),
        .din   ({arid, araddr, arlen, arsize, arburst}),
        .pop   (aq_pop),
        .dout  (ar_dout),
        .full  (ar_full),
        .empty (ar_empty),
        .count ()
    );

    burst_addr_gen burst_addr_gen_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .aq_valid  (!ar_empty),
        .aq_id     (aq_id),
        .aq_addr   (aq_addr),
        .aq_len    (aq_len),
        .aq_size   (aq_size),
        .aq_burst  (burst_type_e'(aq_burst_raw)),
        .stall     (stall),
        .pop       (aq_pop),
        .m_re      (m_re),
        .m_raddr   (m_raddr),
        .beat_id   (beat_id),
        .beat_resp (beat_resp),
        .beat_last (beat_last)
    );

    // ------------------------------------------------------------------
    // Return side
    // ------------------------------------------------------------------
    read_return_pipe read_return_pipe_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .m_re      (m_re),
        .beat_id   (beat_id),
        .beat_resp (beat_resp),
        .beat_last (beat_last),
        .m_rdata   (m_rdata),
        .rff_count (rff_count),
        .rff_push  (rff_push),
        .rff_din   (rff_din),
        .stall     (stall)
    );

    // Stall keeps this buffer from overflowing, so full is not needed
    sync_fifo #(
        .DEPTH (`ASI_R_DEPTH),
        .WIDTH (R_W)
    ) r_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rff_push),
        .din   (rff_din),
        .pop   (rvalid && rready),
        .dout  (r_dout),
        .full  (),
        .empty (r_empty),
        .count (rff_count)
    );

    // R outputs straight from the buffer head, stable until popped
    assign rvalid = !r_empty;
    assign {rid, rdata, rresp_raw, rlast} = r_dout;
    assign rresp  = resp_e'(rresp_raw);

endmodule

/* source/burst_addr_gen.sv */
// ----------------------------------------------------------------------
// Burst engine for the AXI4 read slave
// Pops bursts from the AR buffer and issues one memory read per beat
// Handles alignment, FIXED/INCR stepping, 4 KB hold and size errors
// ----------------------------------------------------------------------
`include "asi_settings.svh"
`timescale 1ns/1ps

module burst_addr_gen import asi_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // AR buffer head
    input  logic        aq_valid,
    input  axi_id_t     aq_id,
    input  axi_addr_t   aq_addr,
    input  axi_len_t    aq_len,
    input  axi_size_t   aq_size,
    input  burst_type_e aq_burst,
    // Credit from the return pipe
    input  logic        stall,
    output logic        pop,
    // Memory read port
    output logic        m_re,
    output axi_addr_t   m_raddr,
    // Beat tags, valid with m_re
    output axi_id_t     beat_id,
    output resp_e       beat_resp,
    output logic        beat_last
);

    localparam axi_size_t MAX_SIZE = axi_size_t'(`ASI_MAX_SIZE);
    localparam axi_addr_t ALL_ONES = '1;

    burst_phase_e phase;
    burst_phase_e phase_nxt;

    // Latched burst fields for beats 1..len
    axi_id_t      id_q;
    axi_len_t     len_q;
    axi_size_t    size_q;
    burst_type_e  burst_q;
    axi_addr_t    addr_q;
    axi_len_t     cnt;

    axi_addr_t    start_aligned;
    axi_size_t    cur_size;
    logic         burst_beat;

    // ------------------------------------------------------------------
    // Address stepping
    // ------------------------------------------------------------------
    // FIXED keeps the address, every other type steps like INCR.
    // A step into the next 4 KB page is refused and the address holds
    function automatic axi_addr_t step_addr(input axi_addr_t   addr,
                                            input axi_size_t   size,
                                            input burst_type_e burst);
        axi_addr_t sum;
        sum = (burst == BT_FIXED) ? addr : addr + (axi_addr_t'(1) << size);
        return (sum[12] != addr[12]) ? addr : sum;
    endfunction

    // Start address rounded down to the transfer size
    assign start_aligned = aq_addr & (ALL_ONES << aq_size);

    // First beat goes out together with the pop
    assign pop        = (phase == BP_FIRST) && aq_valid && !stall;
    // Later beats, one per unstalled cycle
    assign burst_beat = (phase == BP_BURST) && !stall;
    assign m_re       = pop || burst_beat;

    // Memory address and tags, taken from the FIFO head on the first beat
    always_comb begin
        if (phase == BP_FIRST) begin
            m_raddr   = start_aligned;
            beat_id   = aq_id;
            cur_size  = aq_size;
            beat_last = (aq_len == '0);
        end else begin
            m_raddr   = addr_q;
            beat_id   = id_q;
            cur_size  = size_q;
            beat_last = (cnt == len_q);
        end
    end

    // Sizes wider than the data bus get SLVERR on every beat
    assign beat_resp = (cur_size > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY;

    // ------------------------------------------------------------------
    // Phase FSM
    // ------------------------------------------------------------------
    always_comb begin
        phase_nxt = phase;
        case (phase)
            BP_IDLE:  phase_nxt = BP_FIRST;
            // Single beat bursts stay in BP_FIRST
            BP_FIRST: if (pop && aq_len != '0) phase_nxt = BP_BURST;
            BP_BURST: if (burst_beat && beat_last) phase_nxt = BP_FIRST;
            default:  phase_nxt = BP_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= BP_IDLE;
            cnt   <= '0;
        end else begin
            phase <= phase_nxt;
            // Beat 0 leaves with the pop, so counting resumes at 1
            if (pop)
                cnt <= axi_len_t'(1);
            else if (burst_beat)
                cnt <= cnt + 1'b1;
        end
    end

    // Burst fields and running address
    always_ff @(posedge clk) begin
        if (pop) begin
            id_q    <= aq_id;
            len_q   <= aq_len;
            size_q  <= aq_size;
            burst_q <= aq_burst;
            addr_q  <= step_addr(start_aligned, aq_size, aq_burst);
        end else if (burst_beat) begin
            addr_q  <= step_addr(addr_q, size_q, burst_q);
        end
    end

endmodule

/* source/read_return_pipe.sv */
// ----------------------------------------------------------------------
// Read return pipe
// Delays beat tags by the memory latency to meet the returning data
// and keeps the in-flight credit that throttles new reads
// ----------------------------------------------------------------------
`include "asi_settings.svh"
`timescale 1ns/1ps

module read_return_pipe import asi_pkg::*; (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               m_re,
    input  axi_id_t                            beat_id,
    input  resp_e                              beat_resp,
    input  logic                               beat_last,
    input  axi_data_t                          m_rdata,
    input  logic [$clog2(`ASI_R_DEPTH+1)-1:0]  rff_count,
    output logic                               rff_push,
    output logic [`ASI_IW+`ASI_DW+2:0]         rff_din,
    output logic                               stall
);

    localparam int WAIT  = `ASI_RAM_WAIT;
    localparam int TAG_W = `ASI_IW + 3;
    localparam int SUM_W = $clog2(`ASI_R_DEPTH + WAIT + 1);

    // One stage per wait state
    logic [WAIT-1:0]  vld_sr;
    logic [TAG_W-1:0] tag_sr [WAIT];
    logic [SUM_W-1:0] occupancy;

    // Tag fields at the pipe output
    axi_id_t          d_id;
    logic [1:0]       d_resp;
    logic             d_last;

    // Valid flags, one bit per read in flight
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
        end else begin
            vld_sr[0] <= m_re;
            for (int i = 1; i < WAIT; i++) vld_sr[i] <= vld_sr[i-1];
        end
    end

    // Tags travel alongside
    always_ff @(posedge clk) begin
        tag_sr[0] <= {beat_id, beat_resp, beat_last};
        for (int i = 1; i < WAIT; i++) tag_sr[i] <= tag_sr[i-1];
    end

    // Memory data arrives in the same cycle as the last stage
    assign {d_id, d_resp, d_last} = tag_sr[WAIT-1];
    assign rff_push = vld_sr[WAIT-1];
    assign rff_din  = {d_id, m_rdata, d_resp, d_last};

    // Buffered beats plus reads still in the memory
    always_comb begin
        occupancy = SUM_W'(rff_count);
        for (int i = 0; i < WAIT; i++) occupancy = occupancy + SUM_W'(vld_sr[i]);
    end

    // One slot of margin for the read issued this cycle
    assign stall = (occupancy >= SUM_W'(`ASI_R_DEPTH - 1));

endmodule

/* source/sync_fifo.sv */
// ----------------------------------------------------------------------
// Single clock FIFO, first word fall through
// Head entry shows on dout whenever the FIFO holds data
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module sync_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 8
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  logic [WIDTH-1:0]           din,
    input  logic                       pop,
    output logic [WIDTH-1:0]           dout,
    output logic                       full,
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    // Pointer width, at least one bit for a single entry FIFO
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic             do_push;
    logic             do_pop;

    // Wrap at DEPTH so any depth works, not only powers of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == '0);
    assign dout  = mem[rd_ptr];

    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)  rd_ptr <= next_ptr(rd_ptr);
            // Simultaneous push and pop leave the count unchanged
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= din;
    end

endmodule

/* tb.f */
+incdir+include
source/asi_pkg.sv
source/sync_fifo.sv
source/burst_addr_gen.sv
source/read_return_pipe.sv
source/asi_read_slave.sv
verif/asi_read_assertions.sv
verif/tb_asi_read.sv

/* verif/asi_read_assertions.sv */
// ----------------------------------------------------------------------
// Protocol assertions for the AXI4 read slave
// R channel stability, reset values, credit stall and AR ready
// ----------------------------------------------------------------------
`include "asi_settings.svh"
`timescale 1ns/1ps

module asi_read_assertions import asi_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      arvalid,
    input logic      arready,
    input logic      aq_pop,
    input logic      rvalid,
    input logic      rready,
    input axi_id_t   rid,
    input axi_data_t rdata,
    input resp_e     rresp,
    input logic      rlast,
    input logic      m_re,
    input logic      stall
);

    localparam int AR_CW = $clog2(`ASI_AR_DEPTH + 1);

    // Bursts held in the address FIFO, counted from AR handshakes and pops
    logic [AR_CW-1:0] ar_level;

    // Failed assertions so far, read by the testbench
    int               fail_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_level <= '0;
        end else begin
            ar_level <= ar_level + AR_CW'(arvalid && arready) - AR_CW'(aq_pop);
        end
    end

    // A stalled R beat keeps every field until the master takes it
    r_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rvalid && !rready) |=> (rvalid && $stable(rid) && $stable(rdata)
                                 && $stable(rresp) && $stable(rlast)))
        else begin
            fail_count++;
            $error("R channel changed while waiting for rready");
        end

    // Nothing leaves the slave while reset is held
    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> (!rvalid && !m_re))
        else begin
            fail_count++;
            $error("rvalid or m_re high during reset");
        end

    // No memory read without a free credit
    no_read_on_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> !m_re)
        else begin
            fail_count++;
            $error("m_re issued while stall was high");
        end

    // AR back-pressure only comes from a full address FIFO
    arready_when_space: assert property (@(posedge clk) disable iff (!rst_n)
        !arready |-> (ar_level == AR_CW'(`ASI_AR_DEPTH)))
        else begin
            fail_count++;
            $error("arready low with room in the address FIFO");
        end

endmodule

bind asi_read_slave asi_read_assertions asi_read_assertions_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .arvalid (arvalid),
    .arready (arready),
    .aq_pop  (aq_pop),
    .rvalid  (rvalid),
    .rready  (rready),
    .rid     (rid),
    .rdata   (rdata),
    .rresp   (rresp),
    .rlast   (rlast),
    .m_re    (m_re),
    .stall   (stall)
);

/* verif/tb_asi_read.sv */
// ----------------------------------------------------------------------
// Testbench for the AXI4 read slave
// Random bursts, memory model and an expected-beat reference queue
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "asi_settings.svh"

module tb_asi_read import asi_pkg::*; ();

    localparam int        NB       = 45;
    localparam int        TIMEOUT  = 4000;
    localparam int        WAIT     = `ASI_RAM_WAIT;
    localparam int        MAX_SIZE = `ASI_MAX_SIZE;
    // Memory content is address times this odd constant
    localparam axi_data_t MULT     = 32'h9e37_79b1;

    logic        clk;
    logic        rst_n;
    axi_id_t     arid;
    axi_addr_t   araddr;
    axi_len_t    arlen;
    axi_size_t   arsize;
    burst_type_e arburst;
    logic        arvalid;
    logic        arready;
    axi_id_t     rid;
    axi_data_t   rdata;
    resp_e       rresp;
    logic        rlast;
    logic        rvalid;
    logic        rready;
    axi_addr_t   m_raddr;
    logic        m_re;
    axi_data_t   m_rdata;

    integer      seed;
    string       test_name;
    logic        bp_on;
    int          cyc;
    logic        rdy_pat [1024];
    axi_addr_t   addr_pipe [WAIT+1];
    logic        re_pipe [WAIT+1];

    // Burst list, filled once at time zero
    axi_id_t     g_id    [NB];
    axi_addr_t   g_addr  [NB];
    axi_len_t    g_len   [NB];
    axi_size_t   g_size  [NB];
    burst_type_e g_burst [NB];

    // Expected R beats in order of arrival
    axi_data_t   exp_data_q [$];
    axi_id_t     exp_id_q   [$];
    resp_e       exp_resp_q [$];
    logic        exp_last_q [$];

    asi_read_slave asi_read_slave_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .m_raddr (m_raddr),
        .m_re    (m_re),
        .m_rdata (m_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Error reporting and compares
    // ------------------------------------------------------------------
    task automatic report_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string what, input axi_data_t exp, input axi_data_t act);
        if (exp !== act)
            report_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                   test_name, what, exp, act));
    endtask

    task automatic check_id(input string what, input axi_id_t exp, input axi_id_t act);
        if (exp !== act)
            report_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                   test_name, what, exp, act));
    endtask

    task automatic check_resp(input string what, input resp_e exp, input resp_e act);
        if (exp !== act)
            report_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                   test_name, what, exp, act));
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act)
            report_error($sformatf("[FAIL] %s %s: expected %b, actual %b",
                                   test_name, what, exp, act));
    endtask

    // Bound protocol assertions count their failures
    always @(negedge clk) begin
        if (asi_read_slave_inst.asi_read_assertions_inst.fail_count != 0)
            report_error("Protocol assertion failed in the bound checker");
    end

    // ------------------------------------------------------------------
    // Memory model and R channel
    // ------------------------------------------------------------------
    // Address and read enable shift down the line each cycle
    always @(negedge clk) begin
        for (int i = WAIT; i > 0; i--) begin
            addr_pipe[i] = addr_pipe[i-1];
            re_pipe[i]   = re_pipe[i-1];
        end
        addr_pipe[0] = m_raddr;
        re_pipe[0]   = m_re;
        // Data only in the cycle WAIT after a read, undriven otherwise
        m_rdata = re_pipe[WAIT] ? axi_data_t'(addr_pipe[WAIT]) * MULT : 'x;
    end

    // Random back-pressure only inside the matching group
    always @(negedge clk) begin
        cyc = cyc + 1;
        rready = bp_on ? rdy_pat[cyc % 1024] : 1'b1;
    end

    // Every handshaken beat is matched against the queue head
    always @(posedge clk) begin
        if (rst_n && rvalid && rready) begin
            if (exp_data_q.size() == 0) begin
                report_error("R beat returned with no burst outstanding");
            end else begin
                check_data("rdata", exp_data_q.pop_front(), rdata);
                check_id("rid", exp_id_q.pop_front(), rid);
                check_resp("rresp", exp_resp_q.pop_front(), rresp);
                check_flag("rlast", exp_last_q.pop_front(), rlast);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------
    task automatic make_stimulus();
        for (int i = 0; i < NB; i++) begin
            g_id[i]    = axi_id_t'($random(seed));
            g_addr[i]  = axi_addr_t'($random(seed));
            g_len[i]   = axi_len_t'($random(seed) & 15);
            g_size[i]  = axi_size_t'({$random(seed)} % 3);
            g_burst[i] = BT_INCR;
            if (i >= 12 && i < 16) g_burst[i] = BT_FIXED;
            // Eight bytes per beat on a four byte bus
            if (i >= 16 && i < 18) g_size[i] = 3'd3;
            // Sixteen words from just below a 4 KB page end
            if (i >= 18 && i < 21) begin
                g_size[i] = 3'd2;
                g_len[i]  = 8'd15;
                g_addr[i] = {g_addr[i][15:12], 8'hfe, g_addr[i][3:0]};
            end
            if (i >= 21) begin
                g_size[i]  = axi_size_t'($random(seed) & 3);
                g_burst[i] = burst_type_e'($random(seed) & 3);
            end
        end
        // Ready about three cycles in four
        for (int k = 0; k < 1024; k++) rdy_pat[k] = (($random(seed) & 3) != 0);
    endtask

    task automatic model_burst(input int i);
        axi_addr_t a;
        axi_addr_t nxt;
        resp_e     r;
        a = (g_addr[i] >> g_size[i]) << g_size[i];
        r = (int'(g_size[i]) > MAX_SIZE) ? RESP_SLVERR : RESP_OKAY;
        for (int n = 0; n <= int'(g_len[i]); n++) begin
            exp_data_q.push_back(axi_data_t'(a) * MULT);
            exp_id_q.push_back(g_id[i]);
            exp_resp_q.push_back(r);
            exp_last_q.push_back(n == int'(g_len[i]));
            nxt = (g_burst[i] == BT_FIXED) ? a : a + (axi_addr_t'(1) << g_size[i]);
            // Stay on the last address rather than enter the next page
            if (nxt[12] == a[12]) a = nxt;
        end
    endtask

    task automatic send_burst(input int i);
        int t;
        @(negedge clk);
        arid    = g_id[i];
        araddr  = g_addr[i];
        arlen   = g_len[i];
        arsize  = g_size[i];
        arburst = g_burst[i];
        arvalid = 1'b1;
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!arready && t < TIMEOUT);
        if (!arready) report_error("AR handshake timed out");
        else model_burst(i);
    endtask

    task automatic wait_drain();
        int t;
        t = 0;
        while (exp_data_q.size() != 0 && t < TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        if (exp_data_q.size() != 0) report_error("Timed out waiting for R beats");
    endtask

    task automatic run_group(input string name, input int first, input int last,
                             input logic bp);
        test_name = name;
        bp_on     = bp;
        for (int i = first; i <= last; i++) send_burst(i);
        @(negedge clk);
        arvalid = 1'b0;
        wait_drain();
        bp_on = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        seed      = 32'h47ec_e0e8;
        test_name = "reset";
        rst_n     = 1'b0;
        arid      = '0;
        araddr    = '0;
        arlen     = '0;
        arsize    = '0;
        arburst   = BT_INCR;
        arvalid   = 1'b0;
        rready    = 1'b0;
        m_rdata   = '0;
        bp_on     = 1'b0;
        cyc       = 0;
        for (int i = 0; i <= WAIT; i++) begin
            addr_pipe[i] = '0;
            re_pipe[i]   = 1'b0;
        end
        make_stimulus();

        repeat (4) @(posedge clk);
        @(negedge clk);
        check_flag("m_re in reset", 1'b0, m_re);
        check_flag("rvalid in reset", 1'b0, rvalid);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("arready after reset", 1'b1, arready);
        check_flag("rvalid after reset", 1'b0, rvalid);
        check_flag("m_re after reset", 1'b0, m_re);

        run_group("incr", 0, 11, 1'b0);
        run_group("fixed", 12, 15, 1'b0);
        run_group("slverr", 16, 17, 1'b0);
        run_group("boundary", 18, 20, 1'b0);
        run_group("backpressure", 21, NB - 1, 1'b1);

        // Let any stray beat surface before the verdict
        repeat (20) @(negedge clk);
        if (exp_data_q.size() == 0 && !rvalid &&
            asi_read_slave_inst.asi_read_assertions_inst.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            report_error("R beats left over or protocol assertion failed at the end");
        end
    end

endmodule
